//--- dcache.f
+incdir+common
common/dcache_pkg.sv
dcache/dcache_tag_array.sv
dcache/dcache_data_ram.sv
dcache/dcache_ctrl.sv
logic/axi_mem_slave.sv
logic/dcache_top.sv
sim/dcache_assert.sv
sim/dcache_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := dcache_tb
FILELIST   := dcache.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Some tests failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tb;
	import dcache_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 4;
	localparam int SEED = 29637;
	localparam int MEM_LATENCY = 2;
	localparam int N_WIDE = 300;
	localparam int N_NARROW = 200;
	// counting 3, write hit 4, eviction 18
	localparam int N_DIRECTED = 25;
	// worst case is a read miss: lookup, burst wait, refill, re-lookup, ready, gap
	localparam int OP_CYCLES = 2 * (`DCACHE_REFILL_BEATS + MEM_LATENCY + 6);
	localparam int TIMEOUT_NS =
		(RESET_CYCLES + 4 + (N_WIDE + N_NARROW + N_DIRECTED) * OP_CYCLES) * CLK_PERIOD;

	logic clk;
	logic rst;
	logic valid;
	cpu_req_t req;
	logic ready;
	data_t rdata;
	count_t hit_count;
	count_t miss_count;

	data_t ref_mem [`DCACHE_MEM_WORDS];
	int error_count;
	int check_count;

	dcache_top #(
		.MEM_LATENCY(MEM_LATENCY)
	) i_dcache_top (
		.clk       (clk),
		.rst       (rst),
		.valid     (valid),
		.req       (req),
		.ready     (ready),
		.rdata     (rdata),
		.hit_count (hit_count),
		.miss_count(miss_count)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	task automatic check_equal(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// memory word only changes in the bytes the strobe enables
	task automatic update_model(input addr_t addr, input data_t data, input strb_t strb);
		for (int i = 0; i < 8; i++) begin
			if (strb[i]) begin
				ref_mem[addr[13:3]][i*8 +: 8] = data[i*8 +: 8];
			end
		end
	endtask

	// hold the request until the ready pulse, then leave one idle cycle
	task automatic run_access(input cpu_req_t r, output data_t data, output int cycles);
		req = r;
		valid = 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!ready);
		data = rdata;
		valid = 1'b0;
		req = '0;
		@(negedge clk);
	endtask

	task automatic read_word(input string name, input addr_t addr, output int cycles);
		cpu_req_t r;
		data_t data;
		r.addr = addr;
		r.wdata = '0;
		r.strb = '0;
		r.wr = 1'b0;
		run_access(r, data, cycles);
		check_equal(name, ref_mem[addr[13:3]], data);
	endtask

	task automatic write_word(input addr_t addr, input data_t data, input strb_t strb);
		cpu_req_t r;
		data_t rsp_data;
		int cycles;
		r.addr = addr;
		r.wdata = data;
		r.strb = strb;
		r.wr = 1'b1;
		run_access(r, rsp_data, cycles);
		update_model(addr, data, strb);
	endtask

	task automatic random_ops(input string name, input int count, input addr_t base,
			input int words);
		addr_t addr;
		int cycles;
		for (int n = 0; n < count; n++) begin
			addr = base + addr_t'($urandom_range(words - 1) << 3);
			if ($urandom_range(99) < 40) begin
				write_word(addr, {$urandom, $urandom}, strb_t'($urandom));
			end else begin
				read_word($sformatf("%s %h", name, addr), addr, cycles);
			end
		end
	endtask

	// lines of set 5 with tags 1 to 6, a different word in each
	function automatic addr_t same_set_addr(input int k);
		return addr_t'((k << 10) | (5 << 6) | ((k % 8) << 3));
	endfunction

	initial begin
		int cycles;
		count_t hits;
		count_t misses;
		addr_t addr;
		void'($urandom(SEED));
		error_count = 0;
		check_count = 0;
		for (int i = 0; i < `DCACHE_MEM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		rst = 1'b1;
		valid = 1'b0;
		req = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		check_equal("reset_ready", 64'(0), 64'(ready));
		check_equal("reset_ar_valid", 64'(0), 64'(i_dcache_top.ar_valid));
		check_equal("reset_aw_valid", 64'(0), 64'(i_dcache_top.aw_valid));
		check_equal("reset_w_valid", 64'(0), 64'(i_dcache_top.w_valid));
		check_equal("reset_hit_count", 64'(0), 64'(hit_count));
		check_equal("reset_miss_count", 64'(0), 64'(miss_count));

		// write miss bypasses the cache, first read misses, re-read hits
		addr = 32'h0000_2348;
		hits = hit_count;
		misses = miss_count;
		write_word(addr, {$urandom, $urandom}, 8'hff);
		check_equal("count_write_miss", 64'(misses), 64'(miss_count));
		read_word("count_first_read", addr, cycles);
		check_equal("count_miss", 64'(misses + 1), 64'(miss_count));
		check_equal("count_no_hit", 64'(hits), 64'(hit_count));
		read_word("count_reread", addr, cycles);
		check_equal("count_hit", 64'(hits + 1), 64'(hit_count));
		check_equal("hit_latency", 64'(1), 64'(cycles));

		// strobed write to a resident line, next read hits
		addr = 32'h0000_0a90;
		write_word(addr, {$urandom, $urandom}, 8'hff);
		read_word("write_hit_fill", addr, cycles);
		hits = hit_count;
		misses = miss_count;
		write_word(addr, {$urandom, $urandom}, strb_t'($urandom));
		read_word("write_hit_read", addr, cycles);
		check_equal("write_hit_no_refill", 64'(misses), 64'(miss_count));
		check_equal("write_hit_counted", 64'(hits + 1), 64'(hit_count));
		check_equal("write_hit_latency", 64'(1), 64'(cycles));

		// six lines into four ways
		for (int k = 1; k <= 6; k++) begin
			write_word(same_set_addr(k), {$urandom, $urandom}, 8'hff);
		end
		for (int pass = 0; pass < 2; pass++) begin
			for (int k = 1; k <= 6; k++) begin
				read_word($sformatf("eviction %h", same_set_addr(k)), same_set_addr(k), cycles);
			end
		end

		random_ops("random_wide", N_WIDE, 32'h0000_0000, `DCACHE_MEM_WORDS);
		// 1 KB window, one line per set, so it stays resident
		random_ops("random_narrow", N_NARROW, 32'h0000_1400, 128);

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the cache gave no ready within %0d ns of simulation", TIMEOUT_NS);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- sim/dcache_assert.sv
`timescale 1ns/1ps

module dcache_assert (
	input logic                     clk,
	input logic                     rst,
	input logic                     ready,
	input logic                     ar_valid,
	input logic                     ar_ready,
	input logic                     w_valid,
	input dcache_pkg::cache_state_e state,
	input dcache_pkg::way_oh_t      fill_way
);
	import dcache_pkg::*;

	// one ready pulse per request
	ready_pulse: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else $error("ready stayed high for two cycles");

	ar_hold: assert property (@(posedge clk) disable iff (rst)
		ar_valid && !ar_ready |=> ar_valid)
		else $error("ar_valid dropped before ar_ready");

	w_in_write_data: assert property (@(posedge clk) disable iff (rst)
		w_valid |-> state == st_write_data)
		else $error("w_valid outside the write data state");

	// victim pointer feeds the tag fill
	fill_way_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(fill_way))
		else $error("fill way is not one-hot");

endmodule

bind dcache_ctrl dcache_assert i_assert (
	.clk     (clk),
	.rst     (rst),
	.ready   (ready),
	.ar_valid(ar_valid),
	.ar_ready(ar_ready),
	.w_valid (w_valid),
	.state   (state),
	.fill_way(victim)
);

//--- logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
	parameter int MEM_LATENCY = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 valid,
	input  dcache_pkg::cpu_req_t req,
	output logic                 ready,
	output dcache_pkg::data_t    rdata,
	output dcache_pkg::count_t   hit_count,
	output dcache_pkg::count_t   miss_count
);
	import dcache_pkg::*;

	logic ar_valid;
	logic ar_ready;
	ar_chan_t ar;
	logic r_valid;
	r_chan_t r;
	logic aw_valid;
	logic aw_ready;
	aw_chan_t aw;
	logic w_valid;
	logic w_ready;
	w_chan_t w;
	logic b_valid;
	b_chan_t b;

	dcache_ctrl i_ctrl (
		.clk       (clk),
		.rst       (rst),
		.valid     (valid),
		.req       (req),
		.ready     (ready),
		.rdata     (rdata),
		.hit_count (hit_count),
		.miss_count(miss_count),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.ar        (ar),
		.r_valid   (r_valid),
		.r         (r),
		.aw_valid  (aw_valid),
		.aw_ready  (aw_ready),
		.aw        (aw),
		.w_valid   (w_valid),
		.w_ready   (w_ready),
		.w         (w),
		.b_valid   (b_valid),
		.b         (b)
	);

	axi_mem_slave #(
		.LATENCY(MEM_LATENCY)
	) i_mem (
		.clk     (clk),
		.rst     (rst),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.ar      (ar),
		.r_valid (r_valid),
		.r       (r),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.aw      (aw),
		.w_valid (w_valid),
		.w_ready (w_ready),
		.w       (w),
		.b_valid (b_valid),
		.b       (b)
	);

endmodule

//--- logic/axi_mem_slave.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module axi_mem_slave #(
	parameter int LATENCY = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ar_valid,
	output logic                 ar_ready,
	input  dcache_pkg::ar_chan_t ar,
	output logic                 r_valid,
	output dcache_pkg::r_chan_t  r,
	input  logic                 aw_valid,
	output logic                 aw_ready,
	input  dcache_pkg::aw_chan_t aw,
	input  logic                 w_valid,
	output logic                 w_ready,
	input  dcache_pkg::w_chan_t  w,
	output logic                 b_valid,
	output dcache_pkg::b_chan_t  b
);
	import dcache_pkg::*;

	localparam int IDX_W = $clog2(`DCACHE_MEM_WORDS);
	localparam int BEAT_W = $clog2(`DCACHE_REFILL_BEATS);
	localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

	typedef enum logic [2:0] {
		m_idle,
		m_rd_wait,
		m_rd_burst,
		m_wr_data,
		m_wr_wait,
		m_wr_resp
	} mem_state_e;

	mem_state_e st;
	data_t mem [`DCACHE_MEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [BEAT_W-1:0] beat;
	logic [CNT_W-1:0] wait_cnt;
	logic ar_hs;
	logic aw_hs;
	logic w_hs;

	initial begin
		for (int i = 0; i < `DCACHE_MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// reads win when both address channels are valid
	assign ar_ready = (st == m_idle);
	assign aw_ready = (st == m_idle) && !ar_valid;
	assign w_ready = (st == m_wr_data);
	assign ar_hs = ar_valid && ar_ready;
	assign aw_hs = aw_valid && aw_ready;
	assign w_hs = w_valid && w_ready;

	assign r_valid = (st == m_rd_burst);
	assign r.data = mem[idx];
	assign r.last = (beat == BEAT_W'(`DCACHE_REFILL_BEATS - 1));
	assign b_valid = (st == m_wr_resp);
	assign b.resp = RESP_OKAY;

	// the master keeps rready and bready high, so beats never stall
	always_ff @(posedge clk) begin
		if (rst) begin
			st <= m_idle;
			beat <= '0;
			wait_cnt <= '0;
		end else begin
			case (st)
				m_idle: begin
					beat <= '0;
					wait_cnt <= CNT_W'(LATENCY - 1);
					if (ar_hs) begin
						st <= (LATENCY == 0) ? m_rd_burst : m_rd_wait;
					end else if (aw_hs) begin
						st <= m_wr_data;
					end
				end
				m_rd_wait: begin
					if (wait_cnt == '0) begin
						st <= m_rd_burst;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				m_rd_burst: begin
					beat <= beat + 1'b1;
					if (r.last) begin
						st <= m_idle;
					end
				end
				m_wr_data: begin
					wait_cnt <= CNT_W'(LATENCY - 1);
					if (w_hs && w.last) begin
						st <= (LATENCY == 0) ? m_wr_resp : m_wr_wait;
					end
				end
				m_wr_wait: begin
					if (wait_cnt == '0) begin
						st <= m_wr_resp;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				m_wr_resp: st <= m_idle;
				default: st <= m_idle;
			endcase
		end
	end

	// word index, INCR from the line base during a read burst
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			idx <= ar.addr[IDX_W+2:3];
		end else if (aw_hs) begin
			idx <= aw.addr[IDX_W+2:3];
		end else if (st == m_rd_burst) begin
			idx <= idx + 1'b1;
		end
	end

	always @(posedge clk) begin
		if (w_hs) begin
			for (int i = 0; i < 8; i++) begin
				if (w.strb[i]) begin
					mem[idx][i*8 +: 8] <= w.data[i*8 +: 8];
				end
			end
		end
	end

endmodule

//--- dcache/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_ctrl (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 valid,
	input  dcache_pkg::cpu_req_t req,
	output logic                 ready,
	output dcache_pkg::data_t    rdata,
	output dcache_pkg::count_t   hit_count,
	output dcache_pkg::count_t   miss_count,
	output logic                 ar_valid,
	input  logic                 ar_ready,
	output dcache_pkg::ar_chan_t ar,
	input  logic                 r_valid,
	input  dcache_pkg::r_chan_t  r,
	output logic                 aw_valid,
	input  logic                 aw_ready,
	output dcache_pkg::aw_chan_t aw,
	output logic                 w_valid,
	input  logic                 w_ready,
	output dcache_pkg::w_chan_t  w,
	input  logic                 b_valid,
	input  dcache_pkg::b_chan_t  b
);
	import dcache_pkg::*;

	localparam int BEAT_W = $clog2(`DCACHE_REFILL_BEATS);

	cache_state_e state;
	cache_state_e state_next;
	set_t set;
	tag_t tag;
	way_oh_t hit_way;
	way_oh_t hit_way_q;
	way_oh_t victim;
	logic any_hit;
	logic lookup;
	logic rd_hit;
	logic wr_hit;
	logic refill_beat;
	logic refill_done;
	logic b_done;
	logic after_refill;
	logic word_sel_q;
	logic [BEAT_W-1:0] beat;
	data_t strb_bits;
	way_oh_t ram_en;
	logic ram_we;
	bit_en_t ram_bit_en;
	row_addr_t ram_row;
	row_t ram_wdata;
	row_t ram_rdata [`DCACHE_WAYS];
	row_t sel_row;

	assign set = req.addr[9:6];
	assign tag = req.addr[31:10];
	assign any_hit = |hit_way;

	// ready gates the lookup so a held request is not taken twice
	assign lookup = (state == st_idle) && valid && !ready;
	assign rd_hit = lookup && !req.wr && any_hit;
	assign wr_hit = aw_valid && aw_ready && any_hit;
	assign refill_beat = (state == st_refill) && r_valid;
	assign refill_done = refill_beat && r.last;
	assign b_done = (state == st_write_resp) && b_valid && (b.resp == RESP_OKAY);

	assign ar_valid = lookup && !req.wr && !any_hit;
	assign ar.addr = {req.addr[31:6], 6'b0};
	assign aw_valid = lookup && req.wr;
	assign aw.addr = req.addr;
	assign w_valid = (state == st_write_data);
	assign w.data = req.wdata;
	assign w.strb = req.strb;
	assign w.last = 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (ar_valid && ar_ready) begin
					state_next = st_refill;
				end else if (aw_valid && aw_ready) begin
					state_next = st_write_data;
				end
			end
			st_refill: begin
				if (refill_done) begin
					state_next = st_idle;
				end
			end
			st_write_data: begin
				if (w_ready) begin
					state_next = st_write_resp;
				end
			end
			st_write_resp: begin
				if (b_done) begin
					state_next = st_idle;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	// victim rotates while idle and stays put through a refill
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= way_oh_t'(1);
		end else if (state == st_idle) begin
			victim <= {victim[`DCACHE_WAYS-2:0], victim[`DCACHE_WAYS-1]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			beat <= '0;
		end else if (state != st_refill) begin
			beat <= '0;
		end else if (r_valid) begin
			beat <= beat + 1'b1;
		end
	end

	// beat k of a line lands in row k/2, odd beats in the upper half
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			strb_bits[i*8 +: 8] = {8{req.strb[i]}};
		end
		if (state == st_refill) begin
			ram_en = refill_beat ? victim : '0;
			ram_we = refill_beat;
			ram_row = {set, beat[BEAT_W-1:1]};
			ram_bit_en = beat[0] ? {{64{1'b1}}, 64'b0} : {64'b0, {64{1'b1}}};
			ram_wdata = {r.data, r.data};
		end else begin
			ram_en = (rd_hit || wr_hit) ? hit_way : '0;
			ram_we = wr_hit;
			ram_row = req.addr[9:4];
			ram_bit_en = req.addr[3] ? {strb_bits, 64'b0} : {64'b0, strb_bits};
			ram_wdata = {req.wdata, req.wdata};
		end
	end

	dcache_tag_array i_tags (
		.clk     (clk),
		.rst     (rst),
		.set     (set),
		.tag     (tag),
		.hit_way (hit_way),
		.fill    (refill_done),
		.fill_way(victim)
	);

	for (genvar i = 0; i < `DCACHE_WAYS; i++) begin : g_way
		dcache_data_ram i_ram (
			.clk   (clk),
			.en    (ram_en[i]),
			.we    (ram_we),
			.bit_en(ram_bit_en),
			.row   (ram_row),
			.wdata (ram_wdata),
			.rdata (ram_rdata[i])
		);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
			hit_way_q <= '0;
		end else begin
			ready <= rd_hit || b_done;
			if (rd_hit) begin
				hit_way_q <= hit_way;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hit) begin
			word_sel_q <= req.addr[3];
		end
	end

	// hit way is one-hot, so or-ing the SRAM outputs selects it
	always_comb begin
		sel_row = '0;
		for (int i = 0; i < `DCACHE_WAYS; i++) begin
			if (hit_way_q[i]) begin
				sel_row = sel_row | ram_rdata[i];
			end
		end
	end

	assign rdata = word_sel_q ? sel_row[127:64] : sel_row[63:0];

	// the lookup right after a refill belongs to the miss already counted
	always_ff @(posedge clk) begin
		if (rst) begin
			after_refill <= 1'b0;
			hit_count <= '0;
			miss_count <= '0;
		end else begin
			if (refill_done) begin
				after_refill <= 1'b1;
			end else if (rd_hit) begin
				after_refill <= 1'b0;
			end
			if (rd_hit && !after_refill) begin
				hit_count <= hit_count + 1'b1;
			end
			if (ar_valid && ar_ready) begin
				miss_count <= miss_count + 1'b1;
			end
		end
	end

endmodule

//--- dcache/dcache_data_ram.sv
`timescale 1ns/1ps

module dcache_data_ram (
	input  logic                  clk,
	input  logic                  en,
	input  logic                  we,
	input  dcache_pkg::bit_en_t   bit_en,
	input  dcache_pkg::row_addr_t row,
	input  dcache_pkg::row_t      wdata,
	output dcache_pkg::row_t      rdata
);
	import dcache_pkg::*;

	localparam int ROWS = 2 ** $bits(row_addr_t);

	row_t mem [ROWS];

	// single port, a write returns the old row contents
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[row] <= (mem[row] & ~bit_en) | (wdata & bit_en);
			end
			rdata <= mem[row];
		end
	end

endmodule

//--- dcache/dcache_tag_array.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tag_array (
	input  logic                clk,
	input  logic                rst,
	input  dcache_pkg::set_t    set,
	input  dcache_pkg::tag_t    tag,
	output dcache_pkg::way_oh_t hit_way,
	input  logic                fill,
	input  dcache_pkg::way_oh_t fill_way
);
	import dcache_pkg::*;

	tag_t tags [`DCACHE_WAYS][`DCACHE_SETS];
	logic [`DCACHE_SETS-1:0] valid_bits [`DCACHE_WAYS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DCACHE_WAYS; i++) begin
				valid_bits[i] <= '0;
			end
		end else if (fill) begin
			for (int i = 0; i < `DCACHE_WAYS; i++) begin
				if (fill_way[i]) begin
					valid_bits[i][set] <= 1'b1;
				end
			end
		end
	end

	// tag written together with its valid bit at the end of a refill
	always_ff @(posedge clk) begin
		if (fill) begin
			for (int i = 0; i < `DCACHE_WAYS; i++) begin
				if (fill_way[i]) begin
					tags[i][set] <= tag;
				end
			end
		end
	end

	// all ways compared at once
	always_comb begin
		for (int i = 0; i < `DCACHE_WAYS; i++) begin
			hit_way[i] = valid_bits[i][set] && (tags[i][set] == tag);
		end
	end

endmodule

//--- common/dcache_pkg.sv
package dcache_pkg;

	`include "dcache_params.svh"

	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0] strb_t;
	typedef logic [127:0] row_t;
	typedef logic [127:0] bit_en_t;
	typedef logic [21:0] tag_t;
	typedef logic [$clog2(`DCACHE_SETS)-1:0] set_t;
	typedef logic [`DCACHE_WAYS-1:0] way_oh_t;
	// set index plus two bits of row inside the line
	typedef logic [$clog2(`DCACHE_SETS)+1:0] row_addr_t;
	typedef logic [31:0] count_t;

	typedef enum logic [1:0] {
		st_idle,
		st_refill,
		st_write_data,
		st_write_resp
	} cache_state_e;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef struct packed {
		addr_t addr;
		data_t wdata;
		strb_t strb;
		logic wr;
	} cpu_req_t;

	// read request, burst length of a full line is implied
	typedef struct packed {
		addr_t addr;
	} ar_chan_t;

	typedef struct packed {
		data_t data;
		logic last;
	} r_chan_t;

	typedef struct packed {
		addr_t addr;
	} aw_chan_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
		logic last;
	} w_chan_t;

	typedef struct packed {
		logic [1:0] resp;
	} b_chan_t;

endpackage

//--- common/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry
`define DCACHE_SETS 16
`define DCACHE_WAYS 4

// a 64-byte line moves as eight 64-bit beats
`define DCACHE_REFILL_BEATS 8

// backing memory depth in 64-bit words, aliases above address bit 13
`define DCACHE_MEM_WORDS 2048

`endif
